// ==== hdl/exec_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and codes for the execute stage and its neighbours.
// Every RTL file and the testbench take these by scoped names
// (exec_pkg::name).
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package exec_pkg;

	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int alu_opt_w  = 4;
	localparam int mem_opt_w  = 3;
	localparam int exc_code_w = 5;

	typedef logic [word_w-1:0]     word_t;      // data, addresses, hi and lo.
	typedef logic [reg_addr_w-1:0] reg_addr_t;  // r0 is never a bypass source.
	typedef logic [alu_opt_w-1:0]  alu_opt_t;
	typedef logic [mem_opt_w-1:0]  mem_opt_t;
	typedef logic [exc_code_w-1:0] exc_code_t;
	typedef logic [word_w:0]       branch_dest_t;  // top bit selects target from opr2.

	// alu opcodes 13 to 15 are reserved and trap as ec_ri.
	typedef enum alu_opt_t {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_nor  = 4'd5,
		alu_slt  = 4'd6,
		alu_sltu = 4'd7,
		alu_sll  = 4'd8,
		alu_srl  = 4'd9,
		alu_sra  = 4'd10,
		alu_lui  = 4'd11,
		alu_mult = 4'd12
	} alu_op_e;

	typedef enum logic {
		src_reg = 1'b0,
		src_imm = 1'b1
	} alu_src_e;

	typedef enum logic [1:0] {
		br_none   = 2'd0,
		br_eqz    = 2'd1,  // taken when alu result is zero.
		br_nez    = 2'd2,
		br_uncond = 2'd3
	} branch_opt_e;

	localparam mem_opt_t mem_opt_none = '0;

	localparam exc_code_t ec_none = 5'd0;
	localparam exc_code_t ec_ri   = 5'd10;  // reserved instruction.

	localparam logic [3:0] exc_ri_tag = 4'hf;  // upper nibble of badvaddr on ec_ri.

endpackage

// ==== hdl/alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational ALU of the execute stage.
// Arithmetic, logic, compares, shifts and lui; mult yields zero here and is
// computed by the multiplier. Reserved opcodes raise illegal_opt.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module alu (
	input  exec_pkg::word_t    opr1,
	input  exec_pkg::word_t    opr2,
	input  exec_pkg::word_t    sa_imm,
	input  exec_pkg::alu_opt_t opt,
	output exec_pkg::word_t    result,
	output logic               illegal_opt
);

	logic [4:0] shamt;

	assign shamt = sa_imm[4:0];  // shift amount from the instruction.

	always_comb begin
		result      = '0;
		illegal_opt = 1'b0;
		case (opt)
			exec_pkg::alu_add: begin
				result = opr1 + opr2;
			end
			exec_pkg::alu_sub: begin
				result = opr1 - opr2;
			end
			exec_pkg::alu_and: begin
				result = opr1 & opr2;
			end
			exec_pkg::alu_or: begin
				result = opr1 | opr2;
			end
			exec_pkg::alu_xor: begin
				result = opr1 ^ opr2;
			end
			exec_pkg::alu_nor: begin
				result = ~(opr1 | opr2);
			end
			exec_pkg::alu_slt: begin
				result = exec_pkg::word_t'($signed(opr1) < $signed(opr2));
			end
			exec_pkg::alu_sltu: begin
				result = exec_pkg::word_t'(opr1 < opr2);
			end
			// shifts act on opr1 so the source select does not matter.
			exec_pkg::alu_sll: begin
				result = opr1 << shamt;
			end
			exec_pkg::alu_srl: begin
				result = opr1 >> shamt;
			end
			exec_pkg::alu_sra: begin
				result = $signed(opr1) >>> shamt;
			end
			exec_pkg::alu_lui: begin
				result = {opr2[15:0], 16'h0000};
			end
			exec_pkg::alu_mult: begin
				result = '0;  // product comes from mult_unit.
			end
			default: begin
				illegal_opt = 1'b1;  // opcodes 13 to 15.
			end
		endcase
	end

endmodule

// ==== hdl/operand_fwd.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bypass from the ex/mem register back into the execute operands.
// Covers a distance of one instruction; loads leave wb_from_alu low and
// therefore never forward.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module operand_fwd (
	input  exec_pkg::reg_addr_t reg1_addr,
	input  exec_pkg::word_t     reg1_data,
	input  exec_pkg::reg_addr_t reg2_addr,
	input  exec_pkg::word_t     reg2_data,
	input  exec_pkg::reg_addr_t wb_reg_addr_ex2mem,
	input  logic                wb_from_alu,
	input  exec_pkg::word_t     alu_result,
	output exec_pkg::word_t     opr1,
	output exec_pkg::word_t     opr2
);

	logic hit1;
	logic hit2;

	// r0 is hardwired to zero and is never a bypass source.
	assign hit1 = wb_from_alu && (reg1_addr != '0) && (reg1_addr == wb_reg_addr_ex2mem);
	assign hit2 = wb_from_alu && (reg2_addr != '0) && (reg2_addr == wb_reg_addr_ex2mem);

	assign opr1 = hit1 ? alu_result : reg1_data;
	assign opr2 = hit2 ? alu_result : reg2_data;

endmodule

// ==== hdl/mult_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage pipelined signed 32x32 multiplier.
// A start pulse yields hi, lo and a one-cycle done two edges later; a new
// start may come every cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mult_unit (
	input  logic            clk,
	input  logic            rst,
	input  logic            start,
	input  exec_pkg::word_t opr1,
	input  exec_pkg::word_t opr2,
	output exec_pkg::word_t hi,
	output exec_pkg::word_t lo,
	output logic            done
);

	logic signed [2*exec_pkg::word_w-1:0] prod;
	logic                                 prod_valid;

	// stage one forms the full signed product.
	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
		end else begin
			prod_valid <= start;
		end
		if (start) begin
			prod <= $signed(opr1) * $signed(opr2);
		end
	end

	// stage two splits the product into hi and lo.
	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
		end else begin
			done <= prod_valid;
		end
		if (prod_valid) begin
			hi <= prod[2*exec_pkg::word_w-1:exec_pkg::word_w];
			lo <= prod[exec_pkg::word_w-1:0];
		end
	end

endmodule

// ==== hdl/stage_ex.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage register of the pipeline.
// Runs the ALU, resolves branches, folds in the reserved-instruction trap
// and loads the ex/mem fields; stall or clear inserts a bubble. A mult
// latches its operands and pulses mult_start for the multiplier.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stage_ex (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   stall,
	input  logic                   clear,
	input  exec_pkg::alu_opt_t     alu_opt,
	input  exec_pkg::alu_src_e     alu_src,
	input  exec_pkg::word_t        alu_sa_imm,
	input  exec_pkg::branch_opt_e  branch_opt,
	input  exec_pkg::branch_dest_t branch_dest_id2ex,
	input  exec_pkg::mem_opt_t     mem_opt_id2ex,
	input  exec_pkg::reg_addr_t    wb_reg_addr_id2ex,
	input  exec_pkg::exc_code_t    exc_code_id2ex,
	input  exec_pkg::word_t        exc_epc_id2ex,
	input  exec_pkg::word_t        exc_badvaddr_id2ex,
	input  exec_pkg::word_t        opr1,
	input  exec_pkg::word_t        opr2,
	output logic                   branch_flag,
	output exec_pkg::word_t        branch_dest,
	output logic                   wb_from_alu,
	output exec_pkg::word_t        alu_result,
	output exec_pkg::mem_opt_t     mem_opt_ex2mem,
	output exec_pkg::word_t        mem_addr_ex2mem,
	output exec_pkg::word_t        mem_data_ex2mem,
	output exec_pkg::reg_addr_t    wb_reg_addr_ex2mem,
	output exec_pkg::exc_code_t    exc_code_ex2mem,
	output exec_pkg::word_t        exc_epc_ex2mem,
	output exec_pkg::word_t        exc_badvaddr_ex2mem,
	output logic                   mult_start,
	output exec_pkg::word_t        mult_opr1,
	output exec_pkg::word_t        mult_opr2
);

	exec_pkg::word_t alu_opr2;
	exec_pkg::word_t alu_out;
	logic            alu_illegal;
	logic            accept;
	logic            exc_in;      // exception arriving from decode.
	logic            exc_ri;      // reserved opcode without an earlier exception.
	logic            exec_ok;
	logic            branch_taken;
	exec_pkg::word_t branch_target;

	assign alu_opr2 = (alu_src == exec_pkg::src_imm) ? alu_sa_imm : opr2;

	alu alu_i (
		.opr1        (opr1),
		.opr2        (alu_opr2),
		.sa_imm      (alu_sa_imm),
		.opt         (alu_opt),
		.result      (alu_out),
		.illegal_opt (alu_illegal)
	);

	assign accept  = !rst && !stall && !clear;
	assign exc_in  = exc_code_id2ex != exec_pkg::ec_none;
	assign exc_ri  = !exc_in && alu_illegal;
	assign exec_ok = !exc_in && !alu_illegal;

	always_comb begin
		case (branch_opt)
			exec_pkg::br_eqz:    branch_taken = alu_out == '0;
			exec_pkg::br_nez:    branch_taken = alu_out != '0;
			exec_pkg::br_uncond: branch_taken = 1'b1;
			default:             branch_taken = 1'b0;
		endcase
	end

	assign branch_target = branch_dest_id2ex[exec_pkg::word_w] ? opr2 :
		branch_dest_id2ex[exec_pkg::word_w-1:0];

	// branch outputs follow the inputs every edge, stall or not.
	always_ff @(posedge clk) begin
		if (rst) begin
			branch_flag <= 1'b0;
		end else begin
			branch_flag <= branch_taken;
		end
		branch_dest <= branch_target;
	end

	// control fields fall back to a bubble unless a clean instruction lands.
	always_ff @(posedge clk) begin
		mem_opt_ex2mem     <= exec_pkg::mem_opt_none;
		wb_reg_addr_ex2mem <= '0;
		exc_code_ex2mem    <= exec_pkg::ec_none;
		wb_from_alu        <= 1'b0;
		mult_start         <= 1'b0;
		if (accept) begin
			if (exc_in) begin
				exc_code_ex2mem <= exc_code_id2ex;  // earlier stage wins.
			end else if (exc_ri) begin
				exc_code_ex2mem <= exec_pkg::ec_ri;
			end else begin
				mem_opt_ex2mem     <= mem_opt_id2ex;
				wb_reg_addr_ex2mem <= wb_reg_addr_id2ex;
				wb_from_alu        <= mem_opt_id2ex == exec_pkg::mem_opt_none;
				mult_start         <= alu_opt == exec_pkg::alu_mult;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			exc_epc_ex2mem      <= exc_epc_id2ex;
			exc_badvaddr_ex2mem <= exc_badvaddr_id2ex;
			if (exc_ri) begin
				exc_badvaddr_ex2mem <= {exec_pkg::exc_ri_tag,
					{(exec_pkg::word_w-4-exec_pkg::alu_opt_w){1'b0}}, alu_opt};
			end
			if (exec_ok) begin
				alu_result      <= alu_out;
				mem_addr_ex2mem <= alu_out;  // address of load or store.
				mem_data_ex2mem <= opr2;
				if (alu_opt == exec_pkg::alu_mult) begin
					mult_opr1 <= opr1;
					mult_opr2 <= opr2;
				end
			end
		end
	end

endmodule

// ==== hdl/exec_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage top level.
// Connects the operand bypass, the execute stage register and the
// multiplier. Decode fields and register file data enter here.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module exec_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   stall,
	input  logic                   clear,
	input  exec_pkg::alu_opt_t     alu_opt,
	input  exec_pkg::alu_src_e     alu_src,
	input  exec_pkg::word_t        alu_sa_imm,
	input  exec_pkg::branch_opt_e  branch_opt,
	input  exec_pkg::branch_dest_t branch_dest_id2ex,
	input  exec_pkg::mem_opt_t     mem_opt_id2ex,
	input  exec_pkg::reg_addr_t    wb_reg_addr_id2ex,
	input  exec_pkg::exc_code_t    exc_code_id2ex,
	input  exec_pkg::word_t        exc_epc_id2ex,
	input  exec_pkg::word_t        exc_badvaddr_id2ex,
	input  exec_pkg::reg_addr_t    reg1_addr,
	input  exec_pkg::word_t        reg1_data,
	input  exec_pkg::reg_addr_t    reg2_addr,
	input  exec_pkg::word_t        reg2_data,
	output logic                   branch_flag,
	output exec_pkg::word_t        branch_dest,
	output logic                   wb_from_alu,
	output exec_pkg::word_t        alu_result,
	output exec_pkg::mem_opt_t     mem_opt_ex2mem,
	output exec_pkg::word_t        mem_addr_ex2mem,
	output exec_pkg::word_t        mem_data_ex2mem,
	output exec_pkg::reg_addr_t    wb_reg_addr_ex2mem,
	output exec_pkg::exc_code_t    exc_code_ex2mem,
	output exec_pkg::word_t        exc_epc_ex2mem,
	output exec_pkg::word_t        exc_badvaddr_ex2mem,
	output logic                   mult_start,
	output exec_pkg::word_t        hi,
	output exec_pkg::word_t        lo,
	output logic                   mult_done
);

	exec_pkg::word_t opr1;       // operands after bypass.
	exec_pkg::word_t opr2;
	exec_pkg::word_t mult_opr1;
	exec_pkg::word_t mult_opr2;

	operand_fwd operand_fwd_i (
		.reg1_addr          (reg1_addr),
		.reg1_data          (reg1_data),
		.reg2_addr          (reg2_addr),
		.reg2_data          (reg2_data),
		.wb_reg_addr_ex2mem (wb_reg_addr_ex2mem),
		.wb_from_alu        (wb_from_alu),
		.alu_result         (alu_result),
		.opr1               (opr1),
		.opr2               (opr2)
	);

	stage_ex stage_ex_i (
		.clk                 (clk),
		.rst                 (rst),
		.stall               (stall),
		.clear               (clear),
		.alu_opt             (alu_opt),
		.alu_src             (alu_src),
		.alu_sa_imm          (alu_sa_imm),
		.branch_opt          (branch_opt),
		.branch_dest_id2ex   (branch_dest_id2ex),
		.mem_opt_id2ex       (mem_opt_id2ex),
		.wb_reg_addr_id2ex   (wb_reg_addr_id2ex),
		.exc_code_id2ex      (exc_code_id2ex),
		.exc_epc_id2ex       (exc_epc_id2ex),
		.exc_badvaddr_id2ex  (exc_badvaddr_id2ex),
		.opr1                (opr1),
		.opr2                (opr2),
		.branch_flag         (branch_flag),
		.branch_dest         (branch_dest),
		.wb_from_alu         (wb_from_alu),
		.alu_result          (alu_result),
		.mem_opt_ex2mem      (mem_opt_ex2mem),
		.mem_addr_ex2mem     (mem_addr_ex2mem),
		.mem_data_ex2mem     (mem_data_ex2mem),
		.wb_reg_addr_ex2mem  (wb_reg_addr_ex2mem),
		.exc_code_ex2mem     (exc_code_ex2mem),
		.exc_epc_ex2mem      (exc_epc_ex2mem),
		.exc_badvaddr_ex2mem (exc_badvaddr_ex2mem),
		.mult_start          (mult_start),
		.mult_opr1           (mult_opr1),
		.mult_opr2           (mult_opr2)
	);

	mult_unit mult_unit_i (
		.clk   (clk),
		.rst   (rst),
		.start (mult_start),
		.opr1  (mult_opr1),
		.opr2  (mult_opr2),
		.hi    (hi),
		.lo    (lo),
		.done  (mult_done)
	);

endmodule

// ==== test/tb_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running clock for the execute stage testbench.
// The period is set by a parameter; the first edge is a rising one.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock #(
	parameter realtime period = 10ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;  // 50 percent duty.
	end

endmodule

// ==== test/exec_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks bound into the execute stage register.
// Covers reset values, bubbles under stall and clear, exception priority
// and the mult_start pulse one edge after every accepted mult.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module exec_assertions (
	input logic                clk,
	input logic                rst,
	input logic                stall,
	input logic                clear,
	input exec_pkg::alu_opt_t  alu_opt,
	input exec_pkg::exc_code_t exc_code_id2ex,
	input exec_pkg::mem_opt_t  mem_opt_ex2mem,
	input exec_pkg::reg_addr_t wb_reg_addr_ex2mem,
	input exec_pkg::exc_code_t exc_code_ex2mem,
	input logic                wb_from_alu,
	input logic                mult_start,
	input logic                branch_flag
);

	logic accept;
	logic bubble;
	logic mult_in;

	assign accept  = !rst && !stall && !clear;
	assign bubble  = (mem_opt_ex2mem == exec_pkg::mem_opt_none) && (wb_reg_addr_ex2mem == '0) &&
		!wb_from_alu && !mult_start;  // exc_code is checked apart.
	assign mult_in = accept && (exc_code_id2ex == exec_pkg::ec_none) &&
		(alu_opt == exec_pkg::alu_mult);

	reset_state: assert property (@(posedge clk)
		rst |=> bubble && !branch_flag && (exc_code_ex2mem == exec_pkg::ec_none))
		else $error("control fields not cleared after reset");

	hold_bubble: assert property (@(posedge clk)
		(stall || clear) |=> bubble && (exc_code_ex2mem == exec_pkg::ec_none))
		else $error("stall or clear did not load a bubble");

	exc_pass: assert property (@(posedge clk)
		(accept && (exc_code_id2ex != exec_pkg::ec_none)) |=>
		bubble && (exc_code_ex2mem == $past(exc_code_id2ex)))
		else $error("incoming exception code not passed through");

	exc_reserved: assert property (@(posedge clk)
		(accept && (exc_code_id2ex == exec_pkg::ec_none) && (alu_opt > 4'd12)) |=>
		bubble && (exc_code_ex2mem == exec_pkg::ec_ri))
		else $error("reserved opcode did not raise ec_ri");

	mult_issue: assert property (@(posedge clk) disable iff (rst)
		mult_start |-> $past(mult_in))
		else $error("mult_start without an accepted mult");

	mult_latency: assert property (@(posedge clk) disable iff (rst)
		mult_in |=> mult_start)
		else $error("accepted mult did not pulse mult_start one edge later");

endmodule

// ==== test/exec_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the execute stage top level.
// Drives random decode fields, register data, stall and clear on falling
// edges and checks every output against a reference model each cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module exec_tb;

	localparam int reset_cycles = 16;
	localparam int num_instr    = 2000;
	localparam int drain_cycles = 4;     // lets the last mult reach mult_done.
	localparam int max_cycles   = 2500;  // reset, instructions and drain with margin.

	logic clk;
	logic rst;
	logic stall;
	logic clear;
	exec_pkg::alu_opt_t     alu_opt;
	exec_pkg::alu_src_e     alu_src;
	exec_pkg::word_t        alu_sa_imm;
	exec_pkg::branch_opt_e  branch_opt;
	exec_pkg::branch_dest_t branch_dest_id2ex;
	exec_pkg::mem_opt_t     mem_opt_id2ex;
	exec_pkg::reg_addr_t    wb_reg_addr_id2ex;
	exec_pkg::exc_code_t    exc_code_id2ex;
	exec_pkg::word_t        exc_epc_id2ex;
	exec_pkg::word_t        exc_badvaddr_id2ex;
	exec_pkg::reg_addr_t    reg1_addr;
	exec_pkg::word_t        reg1_data;
	exec_pkg::reg_addr_t    reg2_addr;
	exec_pkg::word_t        reg2_data;
	logic                   branch_flag;
	exec_pkg::word_t        branch_dest;
	logic                   wb_from_alu;
	exec_pkg::word_t        alu_result;
	exec_pkg::mem_opt_t     mem_opt_ex2mem;
	exec_pkg::word_t        mem_addr_ex2mem;
	exec_pkg::word_t        mem_data_ex2mem;
	exec_pkg::reg_addr_t    wb_reg_addr_ex2mem;
	exec_pkg::exc_code_t    exc_code_ex2mem;
	exec_pkg::word_t        exc_epc_ex2mem;
	exec_pkg::word_t        exc_badvaddr_ex2mem;
	logic                   mult_start;
	exec_pkg::word_t        hi;
	exec_pkg::word_t        lo;
	logic                   mult_done;

	// reference model state after the last edge.
	logic                exp_wfa;
	exec_pkg::word_t     exp_result;
	exec_pkg::mem_opt_t  exp_mem_opt;
	exec_pkg::word_t     exp_mem_addr;
	exec_pkg::word_t     exp_mem_data;
	exec_pkg::reg_addr_t exp_wb_reg;
	exec_pkg::exc_code_t exp_exc_code;
	exec_pkg::word_t     exp_epc;
	exec_pkg::word_t     exp_badvaddr;
	logic                exp_mult_start;
	exec_pkg::word_t     exp_mopr1;
	exec_pkg::word_t     exp_mopr2;
	logic                exp_br_flag;
	exec_pkg::word_t     exp_br_dest;
	logic                q1_valid;   // multiplier stage one.
	logic signed [63:0]  q1_prod;
	logic                q2_valid;   // multiplier stage two.
	exec_pkg::word_t     q2_hi;
	exec_pkg::word_t     q2_lo;
	logic                res_known;  // data fields have no reset value.
	logic                exc_known;
	logic                br_known;
	int                  cycle_cnt = 0;

	tb_clock #(.period(10ns)) tb_clock_i (.clk(clk));

	exec_top exec_top_i (.*);

	bind stage_ex exec_assertions exec_assertions_i (
		.clk                (clk),
		.rst                (rst),
		.stall              (stall),
		.clear              (clear),
		.alu_opt            (alu_opt),
		.exc_code_id2ex     (exc_code_id2ex),
		.mem_opt_ex2mem     (mem_opt_ex2mem),
		.wb_reg_addr_ex2mem (wb_reg_addr_ex2mem),
		.exc_code_ex2mem    (exc_code_ex2mem),
		.wb_from_alu        (wb_from_alu),
		.mult_start         (mult_start),
		.branch_flag        (branch_flag)
	);

	task automatic fail_stop();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input exec_pkg::word_t exp,
		input exec_pkg::word_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_reg(input string name, input exec_pkg::reg_addr_t exp,
		input exec_pkg::reg_addr_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_mem_opt(input string name, input exec_pkg::mem_opt_t exp,
		input exec_pkg::mem_opt_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_exc(input string name, input exec_pkg::exc_code_t exp,
		input exec_pkg::exc_code_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			fail_stop();
		end
	endtask

	// expected alu result from the opcode table.
	function automatic exec_pkg::word_t ref_alu(input exec_pkg::alu_opt_t opt,
		input exec_pkg::word_t a, input exec_pkg::word_t b, input exec_pkg::word_t sa);
		logic [4:0] sh;
		sh = sa[4:0];
		case (opt)
			exec_pkg::alu_add:  return a + b;
			exec_pkg::alu_sub:  return a - b;
			exec_pkg::alu_and:  return a & b;
			exec_pkg::alu_or:   return a | b;
			exec_pkg::alu_xor:  return a ^ b;
			exec_pkg::alu_nor:  return ~(a | b);
			exec_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exec_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			exec_pkg::alu_sll:  return a << sh;
			exec_pkg::alu_srl:  return a >> sh;
			exec_pkg::alu_sra:  return $signed(a) >>> sh;
			exec_pkg::alu_lui:  return {b[15:0], 16'h0000};
			default:            return '0;  // mult and reserved opcodes.
		endcase
	endfunction

	task automatic model_reset();
		exp_wfa        = 1'b0;
		exp_mem_opt    = exec_pkg::mem_opt_none;
		exp_wb_reg     = '0;
		exp_exc_code   = exec_pkg::ec_none;
		exp_mult_start = 1'b0;
		q1_valid       = 1'b0;
		q2_valid       = 1'b0;
		res_known      = 1'b0;
		exc_known      = 1'b0;
		br_known       = 1'b0;
	endtask

	// advance the model by one rising edge with the inputs now driven.
	task automatic model_edge();
		exec_pkg::word_t    a;
		exec_pkg::word_t    b;
		exec_pkg::word_t    res;
		logic               illegal;
		logic               exc_in;
		logic signed [63:0] m1;
		logic signed [63:0] m2;
		a = (exp_wfa && reg1_addr != '0 && reg1_addr == exp_wb_reg) ? exp_result : reg1_data;
		b = (exp_wfa && reg2_addr != '0 && reg2_addr == exp_wb_reg) ? exp_result : reg2_data;
		res = ref_alu(alu_opt, a, (alu_src == exec_pkg::src_imm) ? alu_sa_imm : b, alu_sa_imm);
		illegal = alu_opt > 4'd12;
		exc_in  = exc_code_id2ex != exec_pkg::ec_none;
		case (branch_opt)
			exec_pkg::br_eqz:    exp_br_flag = res == '0;
			exec_pkg::br_nez:    exp_br_flag = res != '0;
			exec_pkg::br_uncond: exp_br_flag = 1'b1;
			default:             exp_br_flag = 1'b0;
		endcase
		exp_br_dest = branch_dest_id2ex[32] ? b : branch_dest_id2ex[31:0];
		br_known = 1'b1;
		q2_valid = q1_valid;
		if (q1_valid) begin
			q2_hi = q1_prod[63:32];
			q2_lo = q1_prod[31:0];
		end
		q1_valid = exp_mult_start;
		if (exp_mult_start) begin
			m1 = $signed(exp_mopr1);  // sign extends to 64 bits.
			m2 = $signed(exp_mopr2);
			q1_prod = m1 * m2;
		end
		exp_mem_opt    = exec_pkg::mem_opt_none;
		exp_wb_reg     = '0;
		exp_exc_code   = exec_pkg::ec_none;
		exp_wfa        = 1'b0;
		exp_mult_start = 1'b0;
		if (!stall && !clear) begin
			exp_epc      = exc_epc_id2ex;
			exp_badvaddr = exc_badvaddr_id2ex;
			exc_known    = 1'b1;
			if (exc_in) begin
				exp_exc_code = exc_code_id2ex;
			end else if (illegal) begin
				exp_exc_code = exec_pkg::ec_ri;
				exp_badvaddr = {exec_pkg::exc_ri_tag, 24'h000000, alu_opt};
			end else begin
				exp_mem_opt  = mem_opt_id2ex;
				exp_wb_reg   = wb_reg_addr_id2ex;
				exp_wfa      = mem_opt_id2ex == exec_pkg::mem_opt_none;
				exp_result   = res;
				exp_mem_addr = res;
				exp_mem_data = b;
				res_known    = 1'b1;
				if (alu_opt == exec_pkg::alu_mult) begin
					exp_mopr1      = a;
					exp_mopr2      = b;
					exp_mult_start = 1'b1;
				end
			end
		end
	endtask

	task automatic check_outputs();
		check_mem_opt("mem_opt_ex2mem", exp_mem_opt, mem_opt_ex2mem);
		check_reg("wb_reg_addr_ex2mem", exp_wb_reg, wb_reg_addr_ex2mem);
		check_exc("exc_code_ex2mem", exp_exc_code, exc_code_ex2mem);
		check_bit("wb_from_alu", exp_wfa, wb_from_alu);
		check_bit("mult_start", exp_mult_start, mult_start);
		check_bit("mult_done", q2_valid, mult_done);
		if (br_known) begin
			check_bit("branch_flag", exp_br_flag, branch_flag);
			check_word("branch_dest", exp_br_dest, branch_dest);
		end
		if (res_known) begin
			check_word("alu_result", exp_result, alu_result);
			check_word("mem_addr_ex2mem", exp_mem_addr, mem_addr_ex2mem);
			check_word("mem_data_ex2mem", exp_mem_data, mem_data_ex2mem);
		end
		if (exc_known) begin
			check_word("exc_epc_ex2mem", exp_epc, exc_epc_ex2mem);
			check_word("exc_badvaddr_ex2mem", exp_badvaddr, exc_badvaddr_ex2mem);
		end
		if (q2_valid) begin
			check_word("hi", q2_hi, hi);
			check_word("lo", q2_lo, lo);
		end
	endtask

	task automatic set_idle(input logic hold);
		stall              = hold;
		clear              = 1'b0;
		alu_opt            = exec_pkg::alu_add;
		alu_src            = exec_pkg::src_reg;
		alu_sa_imm         = '0;
		branch_opt         = exec_pkg::br_none;
		branch_dest_id2ex  = '0;
		mem_opt_id2ex      = exec_pkg::mem_opt_none;
		wb_reg_addr_id2ex  = '0;
		exc_code_id2ex     = exec_pkg::ec_none;
		exc_epc_id2ex      = '0;
		exc_badvaddr_id2ex = '0;
		reg1_addr          = '0;
		reg1_data          = '0;
		reg2_addr          = '0;
		reg2_data          = '0;
	endtask

	// small register range so that forwarding hits are frequent.
	task automatic drive_random();
		alu_opt = exec_pkg::alu_opt_t'($urandom_range(0, 15));
		if ($urandom_range(0, 7) == 0) begin
			alu_opt = exec_pkg::alu_mult;  // extra mults for back-to-back cases.
		end
		alu_src           = exec_pkg::alu_src_e'($urandom_range(0, 1));
		alu_sa_imm        = $urandom();
		branch_opt        = exec_pkg::branch_opt_e'($urandom_range(0, 3));
		branch_dest_id2ex = {1'($urandom_range(0, 1)), $urandom()};
		mem_opt_id2ex     = exec_pkg::mem_opt_none;
		if ($urandom_range(0, 2) == 0) begin
			mem_opt_id2ex = exec_pkg::mem_opt_t'($urandom_range(1, 7));  // loads and stores.
		end
		wb_reg_addr_id2ex = exec_pkg::reg_addr_t'($urandom_range(0, 7));
		exc_code_id2ex    = exec_pkg::ec_none;
		if ($urandom_range(0, 9) == 0) begin
			exc_code_id2ex = exec_pkg::exc_code_t'($urandom_range(1, 31));
		end
		exc_epc_id2ex      = $urandom();
		exc_badvaddr_id2ex = $urandom();
		reg1_addr          = exec_pkg::reg_addr_t'($urandom_range(0, 7));
		reg2_addr          = exec_pkg::reg_addr_t'($urandom_range(0, 7));
		reg1_data          = ($urandom_range(0, 7) == 0) ? 32'h0 : $urandom();
		reg2_data          = ($urandom_range(0, 5) == 0) ? reg1_data : $urandom();
		stall              = $urandom_range(0, 9) == 0;
		clear              = $urandom_range(0, 11) == 0;
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("run did not finish within %0d cycles", max_cycles);
			fail_stop();
		end
	end

	initial begin
		int unsigned seed_val;
		seed_val = $urandom(32'h5606);
		rst = 1'b1;
		set_idle(1'b0);
		model_reset();
		repeat (reset_cycles) @(posedge clk);
		for (int i = 0; i < num_instr; i++) begin
			@(negedge clk);
			check_outputs();
			rst = 1'b0;
			drive_random();
			model_edge();
		end
		repeat (drain_cycles) begin
			@(negedge clk);
			check_outputs();
			set_idle(1'b1);
			model_edge();
		end
		@(negedge clk);
		check_outputs();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== project.f ====
hdl/exec_pkg.sv
hdl/alu.sv
hdl/operand_fwd.sv
hdl/mult_unit.sv
hdl/stage_ex.sv
hdl/exec_top.sv
test/tb_clock.sv
test/exec_assertions.sv
test/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# Exits with status 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module exec_tb -f project.f -o exec_sim; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/exec_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
